// ==== verilog/timingPkg.sv ====
package timingPkg;

    // Clock cycles per microsecond
    // Kept small so simulation stays short
    localparam int clkPerUs = 2;

    // Width of the microsecond divider
    localparam int usDivWidth = (clkPerUs > 1) ? $clog2(clkPerUs) : 1;

    // Beat length until the first tempo command
    localparam int defaultTempoUs = 500;

    // Beat length in microseconds
    typedef logic [15:0] tempoUsT;

    // Microsecond position inside one beat
    typedef logic [15:0] usCountT;

endpackage

// ==== verilog/musicPkg.sv ====
package musicPkg;

    localparam int queueDepth    = 4;                    // Score words held by the player
    localparam int creditWidth   = 3;                    // Holds 0 to queueDepth
    localparam int queuePtrWidth = $clog2(queueDepth);

    // Playable pitch codes, C#3 up to B7
    localparam int minPitchCode = 1;
    localparam int maxPitchCode = 59;

    typedef logic [7:0]  pitchCodeT;
    typedef logic [12:0] periodUsT;                      // 0 plays silence
    typedef logic [7:0]  beatCountT;

    typedef enum logic {
        NOTE    = 1'b0,
        COMMAND = 1'b1
    } scoreKindE;

    typedef enum logic [6:0] {
        SET_TEMPO = 7'd1                                 // Other opcodes are ignored
    } commandOpE;

    typedef struct packed {
        scoreKindE kind;
        logic [6:0] spare;
        pitchCodeT pitchCode;
        beatCountT beats;
    } noteWordT;

    typedef struct packed {
        scoreKindE kind;
        commandOpE opcode;
        timingPkg::tempoUsT argument;
    } commandWordT;

    // The top bit of a 24-bit score word says which view applies
    typedef union packed {
        noteWordT note;
        commandWordT command;
    } scoreWordT;

    // Note handed to the tone generator
    typedef struct packed {
        periodUsT periodUs;
        beatCountT beats;
        timingPkg::tempoUsT tempoUs;
    } noteEventT;

endpackage

// ==== verilog/noteQueue.sv ====
`timescale 1ns/100ps

module noteQueue (
    input  logic                iClk,
    input  logic                rstN,
    input  logic                scoreValid,
    input  musicPkg::scoreWordT scoreWord,
    input  logic                qPop,
    output logic                qValid,
    output musicPkg::scoreWordT qWord,
    output logic                scoreCredit
);
    import musicPkg::*;

    scoreWordT                entries [queueDepth];
    logic [queuePtrWidth-1:0] rdPtr;
    logic [queuePtrWidth-1:0] wrPtr;
    logic [creditWidth-1:0]   count;
    logic                     popOk;

    assign qValid = (count != '0);
    assign qWord  = entries[rdPtr];                      // Head word
    assign popOk  = qPop && qValid;

    // The credit rule keeps the host from overfilling the storage
    always_ff @(posedge iClk) begin
        if (scoreValid) begin
            entries[wrPtr] <= scoreWord;
        end
    end

    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            rdPtr       <= '0;
            wrPtr       <= '0;
            count       <= '0;
            scoreCredit <= 1'b0;
        end else begin
            if (scoreValid) begin
                wrPtr <= wrPtr + 1'b1;                   // Wraps at queueDepth
            end
            if (popOk) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({scoreValid, popOk})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;                      // Both or neither
                end
            endcase
            scoreCredit <= popOk;                        // One credit back per word
        end
    end

endmodule

// ==== verilog/pitchDecoder.sv ====
`timescale 1ns/100ps

module pitchDecoder (
    input  logic                iClk,
    input  logic                rstN,
    input  musicPkg::pitchCodeT pitchCode,
    output musicPkg::periodUsT  periodUs
);
    import musicPkg::*;

    // One million over the equal-tempered frequency gives the period in microseconds
    localparam periodUsT periodTable [minPitchCode:maxPitchCode] = '{
        periodUsT'(1_000_000 / 138),                     // C#3
        periodUsT'(1_000_000 / 146),                     // D3
        periodUsT'(1_000_000 / 155),
        periodUsT'(1_000_000 / 164),                     // E3
        periodUsT'(1_000_000 / 174),
        periodUsT'(1_000_000 / 185),
        periodUsT'(1_000_000 / 196),                     // G3
        periodUsT'(1_000_000 / 207),
        periodUsT'(1_000_000 / 220),                     // A3
        periodUsT'(1_000_000 / 233),
        periodUsT'(1_000_000 / 246),                     // B3
        periodUsT'(1_000_000 / 261),                     // C4
        periodUsT'(1_000_000 / 277),
        periodUsT'(1_000_000 / 293),
        periodUsT'(1_000_000 / 311),
        periodUsT'(1_000_000 / 329),
        periodUsT'(1_000_000 / 349),
        periodUsT'(1_000_000 / 370),
        periodUsT'(1_000_000 / 392),
        periodUsT'(1_000_000 / 415),
        periodUsT'(1_000_000 / 440),                     // A4 reference pitch
        periodUsT'(1_000_000 / 466),
        periodUsT'(1_000_000 / 494),
        periodUsT'(1_000_000 / 523),                     // C5
        periodUsT'(1_000_000 / 554),
        periodUsT'(1_000_000 / 587),
        periodUsT'(1_000_000 / 622),
        periodUsT'(1_000_000 / 659),
        periodUsT'(1_000_000 / 698),
        periodUsT'(1_000_000 / 740),
        periodUsT'(1_000_000 / 784),
        periodUsT'(1_000_000 / 831),
        periodUsT'(1_000_000 / 880),                     // A5
        periodUsT'(1_000_000 / 932),
        periodUsT'(1_000_000 / 988),
        periodUsT'(1_000_000 / 1047),                    // C6
        periodUsT'(1_000_000 / 1109),
        periodUsT'(1_000_000 / 1175),
        periodUsT'(1_000_000 / 1245),
        periodUsT'(1_000_000 / 1319),
        periodUsT'(1_000_000 / 1397),
        periodUsT'(1_000_000 / 1480),
        periodUsT'(1_000_000 / 1568),
        periodUsT'(1_000_000 / 1661),
        periodUsT'(1_000_000 / 1760),                    // A6
        periodUsT'(1_000_000 / 1865),
        periodUsT'(1_000_000 / 1976),
        periodUsT'(1_000_000 / 2093),                    // C7
        periodUsT'(1_000_000 / 2217),
        periodUsT'(1_000_000 / 2349),
        periodUsT'(1_000_000 / 2489),
        periodUsT'(1_000_000 / 2637),
        periodUsT'(1_000_000 / 2794),
        periodUsT'(1_000_000 / 2960),
        periodUsT'(1_000_000 / 3136),
        periodUsT'(1_000_000 / 3322),
        periodUsT'(1_000_000 / 3520),                    // A7
        periodUsT'(1_000_000 / 3729),
        periodUsT'(1_000_000 / 3951)                     // B7
    };

    logic inRange;

    assign inRange = (pitchCode >= minPitchCode) && (pitchCode <= maxPitchCode);

    // Result one cycle after the code
    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            periodUs <= '0;
        end else if (inRange) begin
            periodUs <= periodTable[pitchCode];
        end else begin
            periodUs <= '0;                              // Rest, stop and undefined codes
        end
    end

endmodule

// ==== verilog/scoreInterpreter.sv ====
`timescale 1ns/100ps

module scoreInterpreter (
    input  logic                iClk,
    input  logic                rstN,
    input  logic                qValid,
    input  musicPkg::scoreWordT qWord,
    output logic                qPop,
    output musicPkg::pitchCodeT pitchCode,
    input  musicPkg::periodUsT  periodUs,
    output logic                evValid,
    output musicPkg::noteEventT noteEvent,
    input  logic                evReady
);
    import musicPkg::*;
    import timingPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DECODE,                                          // Waiting on the pitch table
        OFFER
    } stateE;

    stateE   state;
    tempoUsT tempoUs;
    logic    isNote;
    logic    isTempo;
    logic    takeNote;

    assign isNote  = (qWord.note.kind == NOTE);
    assign isTempo = (qWord.command.kind == COMMAND) &&
                     (qWord.command.opcode == SET_TEMPO) &&
                     (qWord.command.argument != '0);      // Zero tempo is ignored

    assign qPop      = (state == IDLE) && qValid;
    assign takeNote  = qPop && isNote;
    assign pitchCode = qWord.note.pitchCode;             // Decoder sees the head directly
    assign evValid   = (state == OFFER);

    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            state   <= IDLE;
            tempoUs <= tempoUsT'(defaultTempoUs);
        end else begin
            case (state)
                IDLE: begin
                    if (takeNote) begin
                        state <= DECODE;
                    end else if (qPop && isTempo) begin
                        tempoUs <= qWord.command.argument;
                    end
                end
                DECODE: begin
                    state <= OFFER;
                end
                OFFER: begin
                    if (evReady) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Beats and tempo are taken at pop time
    always_ff @(posedge iClk) begin
        if (takeNote) begin
            noteEvent.beats   <= qWord.note.beats;
            noteEvent.tempoUs <= tempoUs;
        end
        if (state == DECODE) begin
            noteEvent.periodUs <= periodUs;
        end
    end

endmodule

// ==== verilog/toneGenerator.sv ====
`timescale 1ns/100ps

module toneGenerator (
    input  logic                iClk,
    input  logic                rstN,
    input  logic                evValid,
    input  musicPkg::noteEventT noteEvent,
    output logic                evReady,
    output logic                buzzer,
    output logic                toneActive,
    output musicPkg::periodUsT  currentPeriod
);
    import musicPkg::*;
    import timingPkg::*;

    logic [usDivWidth-1:0]       usDiv;
    logic                        usTick;
    usCountT                     usCount;
    beatCountT                   beatsLeft;
    logic [$bits(periodUsT)-2:0] halfCount;
    logic [$bits(periodUsT)-2:0] halfUs;
    tempoUsT                     noteTempo;
    logic                        accept;
    logic                        beatDone;
    logic                        noteDone;

    assign evReady  = !toneActive;
    assign accept   = evValid && evReady;
    assign usTick   = toneActive && (usDiv == usDivWidth'(clkPerUs - 1));
    assign beatDone = usTick && (usCount == usCountT'(noteTempo - 1'b1));
    assign noteDone = beatDone && (beatsLeft == beatCountT'(1));
    assign halfUs   = currentPeriod[$bits(periodUsT)-1:1];   // Half period rounded down

    always_ff @(posedge iClk) begin
        if (accept) begin
            noteTempo <= noteEvent.tempoUs;
        end
    end

    always_ff @(posedge iClk or negedge rstN) begin
        if (!rstN) begin
            toneActive    <= 1'b0;
            buzzer        <= 1'b0;
            currentPeriod <= '0;
            usDiv         <= '0;
            usCount       <= '0;
            beatsLeft     <= '0;
            halfCount     <= '0;
        end else if (accept) begin
            usDiv     <= '0;
            usCount   <= '0;
            halfCount <= '0;
            beatsLeft <= noteEvent.beats;
            if (noteEvent.beats != '0) begin                 // Zero beats plays nothing
                toneActive    <= 1'b1;
                currentPeriod <= noteEvent.periodUs;
                buzzer        <= (noteEvent.periodUs[$bits(periodUsT)-1:1] != '0);
            end
        end else if (toneActive) begin
            usDiv <= usTick ? '0 : usDiv + 1'b1;
            if (usTick) begin
                usCount <= beatDone ? '0 : usCount + 1'b1;
                if (halfUs != '0) begin                      // Silence never toggles
                    if (halfCount == halfUs - 1'b1) begin
                        halfCount <= '0;
                        buzzer    <= !buzzer;
                    end else begin
                        halfCount <= halfCount + 1'b1;
                    end
                end
                if (beatDone) begin
                    beatsLeft <= beatsLeft - 1'b1;
                end
                if (noteDone) begin                          // Overrides the toggle
                    toneActive    <= 1'b0;
                    buzzer        <= 1'b0;
                    currentPeriod <= '0;
                end
            end
        end
    end

endmodule

// ==== verilog/buzzerPlayer.sv ====
`timescale 1ns/100ps

module buzzerPlayer (
    input  logic                iClk,
    input  logic                rstN,
    input  logic                scoreValid,
    input  musicPkg::scoreWordT scoreWord,
    output logic                scoreCredit,
    output logic                buzzer,
    output logic                toneActive,
    output musicPkg::periodUsT  currentPeriod
);
    import musicPkg::*;

    logic      qValid;
    scoreWordT qWord;
    logic      qPop;
    pitchCodeT pitchCode;
    periodUsT  periodUs;
    logic      evValid;
    noteEventT noteEvent;
    logic      evReady;

    noteQueue uNoteQueue (
        .iClk        (iClk),
        .rstN        (rstN),
        .scoreValid  (scoreValid),
        .scoreWord   (scoreWord),
        .qPop        (qPop),
        .qValid      (qValid),
        .qWord       (qWord),
        .scoreCredit (scoreCredit)
    );

    scoreInterpreter uScoreInterpreter (
        .iClk      (iClk),
        .rstN      (rstN),
        .qValid    (qValid),
        .qWord     (qWord),
        .qPop      (qPop),
        .pitchCode (pitchCode),
        .periodUs  (periodUs),
        .evValid   (evValid),
        .noteEvent (noteEvent),
        .evReady   (evReady)
    );

    pitchDecoder uPitchDecoder (
        .iClk      (iClk),
        .rstN      (rstN),
        .pitchCode (pitchCode),
        .periodUs  (periodUs)
    );

    toneGenerator uToneGenerator (
        .iClk          (iClk),
        .rstN          (rstN),
        .evValid       (evValid),
        .noteEvent     (noteEvent),
        .evReady       (evReady),
        .buzzer        (buzzer),
        .toneActive    (toneActive),
        .currentPeriod (currentPeriod)
    );

endmodule

// ==== tb/buzzerPlayerTb.sv ====
`timescale 1ns/100ps

module buzzerPlayerTb;
    import musicPkg::*;
    import timingPkg::*;

    typedef struct packed {
        periodUsT    periodUs;
        logic [31:0] lengthCycles;                       // Clock cycles toneActive stays high
        tempoUsT     tempoUs;
    } expectedNoteT;

    logic      iClk = 1'b0;
    logic      rstN;
    logic      scoreValid;
    scoreWordT scoreWord;
    logic      scoreCredit;
    logic      buzzer;
    logic      toneActive;
    periodUsT  currentPeriod;

    scoreWordT    scoreWords [$];
    expectedNoteT expectedNotes [$];
    expectedNoteT current;
    string        lengthTest;
    int           burstStart;
    int           sentCount     = 0;
    int           creditCount   = 0;
    int           maxOutstanding = 0;
    int           cycleCount    = 0;
    int           timeoutLimit  = 0;
    int           activeLen;
    int           runLen;
    int           halfCycles;
    logic         prevActive    = 1'b0;
    logic         prevBuzzer    = 1'b0;

    buzzerPlayer UUT (
        .iClk          (iClk),
        .rstN          (rstN),
        .scoreValid    (scoreValid),
        .scoreWord     (scoreWord),
        .scoreCredit   (scoreCredit),
        .buzzer        (buzzer),
        .toneActive    (toneActive),
        .currentPeriod (currentPeriod)
    );

    always #2 iClk = ~iClk;                              // 4 ns period

    task automatic reportMismatch(input string testName, input int expected, input int actual);
        $display("[ERROR] %s expected %0d actual %0d", testName, expected, actual);
        $display("sim failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "stopping on first error");
    endtask

    // Equal-tempered frequencies of the codes in the score
    function automatic int noteFrequency(input pitchCodeT code);
        case (code)
            8'd11:   return 246;                         // B3
            8'd21:   return 440;                         // A4
            8'd24:   return 523;                         // C5
            8'd57:   return 3520;                        // A7
            default: return 0;                           // Rest and undefined codes
        endcase
    endfunction

    function automatic scoreWordT noteWord(input pitchCodeT code, input beatCountT beats);
        scoreWordT w;
        w.note.kind      = NOTE;
        w.note.spare     = '0;
        w.note.pitchCode = code;
        w.note.beats     = beats;
        return w;
    endfunction

    function automatic scoreWordT commandWord(input int op, input tempoUsT arg);
        scoreWordT w;
        w.command.kind     = COMMAND;
        w.command.opcode   = commandOpE'(op);
        w.command.argument = arg;
        return w;
    endfunction

    task automatic buildScore();
        scoreWords.push_back(noteWord(8'd21, 8'd3));
        scoreWords.push_back(noteWord(8'd24, 8'd2));
        scoreWords.push_back(noteWord(8'd0, 8'd1));
        scoreWords.push_back(commandWord(1, 16'd200));   // New beat length
        scoreWords.push_back(noteWord(8'd57, 8'd2));
        scoreWords.push_back(noteWord(8'd99, 8'd1));
        scoreWords.push_back(noteWord(8'd11, 8'd12));    // Long note stalls the interpreter
        burstStart = scoreWords.size();
        scoreWords.push_back(noteWord(8'd70, 8'd1));
        scoreWords.push_back(noteWord(8'd57, 8'd3));
        scoreWords.push_back(commandWord(1, 16'd0));     // Zero tempo has no effect
        scoreWords.push_back(noteWord(8'd21, 8'd2));
        scoreWords.push_back(commandWord(5, 16'd300));   // Unknown opcode
        scoreWords.push_back(noteWord(8'd24, 8'd5));
    endtask

    // Walks the score with the tempo rules and fills the expected notes
    task automatic buildExpected();
        int           freq;
        int           tempo;
        int           total;
        expectedNoteT n;
        tempo = defaultTempoUs;
        total = 0;
        foreach (scoreWords[i]) begin
            if (scoreWords[i].note.kind == NOTE) begin
                freq           = noteFrequency(scoreWords[i].note.pitchCode);
                n.periodUs     = (freq == 0) ? '0 : periodUsT'(1_000_000 / freq);
                n.lengthCycles = scoreWords[i].note.beats * tempo * clkPerUs;
                n.tempoUs      = tempoUsT'(tempo);
                expectedNotes.push_back(n);
                total          = total + n.lengthCycles;
            end else if (scoreWords[i].command.opcode == SET_TEMPO &&
                         scoreWords[i].command.argument != '0) begin
                tempo = scoreWords[i].command.argument;
            end
        end
        timeoutLimit = total + 200;
    endtask

    // Sends the score while the host still holds credits
    task automatic driveScore();
        int gap;
        for (int idx = 0; idx < scoreWords.size(); idx++) begin
            gap = (idx < burstStart) ? ($urandom % 4) : 0;
            repeat (gap) begin
                @(posedge iClk);
                scoreValid <= 1'b0;
            end
            @(posedge iClk);
            while (queueDepth - (sentCount - creditCount) <= 0) begin
                scoreValid <= 1'b0;
                @(posedge iClk);
            end
            scoreValid <= 1'b1;
            scoreWord  <= scoreWords[idx];
            sentCount++;
        end
        @(posedge iClk);
        scoreValid <= 1'b0;
    endtask

    always @(negedge iClk) begin
        if (!rstN) begin
            assert (!scoreCredit && !buzzer && !toneActive && currentPeriod == '0)
                else reportFailure("Outputs left their reset values during reset");
        end else begin
            cycleCount++;
            if (cycleCount > timeoutLimit) begin
                reportFailure($sformatf("Timed out after %0d cycles", cycleCount));
            end
            if (scoreCredit) begin
                creditCount++;
            end
            assert (creditCount <= sentCount && sentCount - creditCount <= queueDepth)
                else reportFailure($sformatf("Bad credit count, %0d sent and %0d returned",
                                             sentCount, creditCount));
            if (sentCount - creditCount > maxOutstanding) begin
                maxOutstanding = sentCount - creditCount;
            end
            if (toneActive && !prevActive) begin         // A note starts
                assert (expectedNotes.size() > 0)
                    else reportFailure("Tone started with no note word pending");
                current    = expectedNotes.pop_front();
                lengthTest = (current.tempoUs == defaultTempoUs) ? "length" : "tempo";
                halfCycles = (int'(current.periodUs) / 2) * clkPerUs;
                activeLen  = 1;
                runLen     = 1;
                assert (buzzer == (halfCycles != 0))
                    else reportMismatch("pitch start", halfCycles != 0, buzzer);
            end else if (toneActive) begin
                activeLen++;
                if (buzzer != prevBuzzer) begin
                    assert (runLen == halfCycles)
                        else reportMismatch("pitch half period", halfCycles, runLen);
                    runLen = 1;
                end else begin
                    runLen++;
                end
            end
            if (toneActive) begin
                assert (currentPeriod == current.periodUs)
                    else reportMismatch("order", current.periodUs, currentPeriod);
                assert (activeLen <= current.lengthCycles)
                    else reportMismatch(lengthTest, current.lengthCycles, activeLen);
                if (halfCycles == 0) begin
                    assert (!buzzer) else reportMismatch("silence", 0, buzzer);
                end else begin
                    assert (runLen <= halfCycles)
                        else reportMismatch("pitch half period", halfCycles, runLen);
                end
            end else begin
                if (prevActive) begin                    // Note just ended
                    assert (activeLen == current.lengthCycles)
                        else reportMismatch(lengthTest, current.lengthCycles, activeLen);
                end
                assert (!buzzer) else reportMismatch("idle buzzer", 0, buzzer);
                assert (currentPeriod == '0)
                    else reportMismatch("idle period", 0, currentPeriod);
            end
            prevActive = toneActive;
            prevBuzzer = buzzer;
        end
    end

    initial begin
        void'($urandom(32'h70fd));
        rstN       = 1'b0;
        scoreValid = 1'b0;
        scoreWord  = '0;
        buildScore();
        buildExpected();
        repeat (3) @(posedge iClk);
        rstN <= 1'b1;
        driveScore();
        while (expectedNotes.size() != 0 || toneActive) begin
            @(posedge iClk);
        end
        repeat (4) @(posedge iClk);                      // Let the last credits settle
        assert (creditCount == sentCount)
            else reportMismatch("credit count", sentCount, creditCount);
        assert (maxOutstanding == queueDepth)
            else reportMismatch("credit burst", queueDepth, maxOutstanding);
        $display("sim passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/timingPkg.sv
verilog/musicPkg.sv
verilog/noteQueue.sv
verilog/pitchDecoder.sv
verilog/scoreInterpreter.sv
verilog/toneGenerator.sv
verilog/buzzerPlayer.sv
tb/buzzerPlayerTb.sv
